/* src/rv32_pkg.sv */
`default_nettype none

package rv32_pkg;

   localparam int XLEN = 32;

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   // Same funct3 values for OP and OP_IMM
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;   // SUB only, no SRA here

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B,
      ALU_BEQ,
      ALU_BNE,
      ALU_JAL,
      ALU_ILLEGAL
   } alu_op_e;

   function automatic logic [4:0] get_rd(input logic [XLEN-1:0] instr);
      return instr[11:7];
   endfunction

   function automatic logic [4:0] get_rs1(input logic [XLEN-1:0] instr);
      return instr[19:15];
   endfunction

   function automatic logic [4:0] get_rs2(input logic [XLEN-1:0] instr);
      return instr[24:20];
   endfunction

   function automatic logic [2:0] get_funct3(input logic [XLEN-1:0] instr);
      return instr[14:12];
   endfunction

   function automatic logic [6:0] get_funct7(input logic [XLEN-1:0] instr);
      return instr[31:25];
   endfunction

   function automatic logic [XLEN-1:0] imm_i(input logic [XLEN-1:0] instr);
      return {{20{instr[31]}}, instr[31:20]};
   endfunction

   function automatic logic [XLEN-1:0] imm_u(input logic [XLEN-1:0] instr);
      return {instr[31:12], 12'b0};
   endfunction

   // Branch offset, bit 0 always zero
   function automatic logic [XLEN-1:0] imm_b(input logic [XLEN-1:0] instr);
      return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   endfunction

   function automatic logic [XLEN-1:0] imm_j(input logic [XLEN-1:0] instr);
      return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
   endfunction

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   // One fetched word with the pc it came from
   typedef struct packed {
      logic [rv32_pkg::XLEN-1:0] pc;
      logic [rv32_pkg::XLEN-1:0] instr;
   } fetch_pkt_t;

   // Queue depth doubles as the starting credit count
   localparam int DEF_QUEUE_DEPTH = 4;

   localparam int DEF_IMEM_WORDS = 256;   // 1 KiB of program

endpackage

`default_nettype wire

/* src/fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Fetch unit to queue, credit based
interface fetch_if #(
   parameter type T = pipe_pkg::fetch_pkt_t
);

   logic push_valid;
   T     push_pkt;
   logic credit;    // One pulse per popped entry
   logic flush;     // Redirect, drop everything queued

   modport producer (
      output push_valid,
      output push_pkt,
      output flush,
      input  credit
   );

   modport buffer (
      input  push_valid,
      input  push_pkt,
      input  flush,
      output credit
   );

endinterface

`default_nettype wire

/* src/issue_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Queue head to execute unit, valid/pop
interface issue_if #(
   parameter type T = pipe_pkg::fetch_pkt_t
);

   logic valid;
   T     pkt;
   logic pop;      // Head leaves in this cycle
   logic flush;

   modport buffer (
      output valid,
      output pkt,
      input  pop,
      input  flush
   );

   modport consumer (
      input  valid,
      input  pkt,
      output pop,
      output flush
   );

endinterface

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
   parameter int QUEUE_DEPTH = pipe_pkg::DEF_QUEUE_DEPTH,
   parameter int IMEM_WORDS  = pipe_pkg::DEF_IMEM_WORDS
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            run_i,
   input  logic                            imem_we_i,
   input  logic [$clog2(IMEM_WORDS)-1:0]   imem_addr_i,
   input  logic [rv32_pkg::XLEN-1:0]       imem_data_i,
   input  logic                            redirect_i,
   input  logic [rv32_pkg::XLEN-1:0]       target_i,
   fetch_if.producer                       fq
);

   localparam int AW = $clog2(IMEM_WORDS);
   localparam int CW = $clog2(QUEUE_DEPTH + 1);

   logic [rv32_pkg::XLEN-1:0] imem [IMEM_WORDS];

   logic [rv32_pkg::XLEN-1:0] pc_q;
   logic [rv32_pkg::XLEN-1:0] fetch_pc;
   logic [rv32_pkg::XLEN-1:0] req_pc;
   logic [rv32_pkg::XLEN-1:0] rdata;
   logic                      req_valid;   // Read in flight, lands next cycle
   logic [CW-1:0]             credit_cnt;
   logic                      issue;

   assign fetch_pc = redirect_i ? target_i : pc_q;

   // A read in flight already holds one credit
   assign issue = run_i && (redirect_i || (credit_cnt > CW'(req_valid)));

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q       <= '0;
         req_valid  <= 1'b0;
         credit_cnt <= CW'(QUEUE_DEPTH);
      end else begin
         req_valid <= issue;   // Redirect kills the old read
         if (issue) begin
            pc_q <= fetch_pc + 32'd4;
         end else if (redirect_i) begin
            pc_q <= target_i;
         end
         if (redirect_i) begin
            credit_cnt <= CW'(QUEUE_DEPTH);   // Queue empties with the flush
         end else begin
            credit_cnt <= credit_cnt - CW'(req_valid) + CW'(fq.credit);
         end
      end
   end

   // Load port and synchronous read
   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
      if (issue) begin
         rdata  <= imem[fetch_pc[AW+1:2]];
         req_pc <= fetch_pc;
      end
   end

   assign fq.push_valid   = req_valid;
   assign fq.push_pkt.pc    = req_pc;
   assign fq.push_pkt.instr = rdata;
   assign fq.flush        = redirect_i;

endmodule

`default_nettype wire

/* src/fetch_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_queue #(
   parameter int  QUEUE_DEPTH = pipe_pkg::DEF_QUEUE_DEPTH,
   parameter type T           = pipe_pkg::fetch_pkt_t
) (
   input  logic     clk,
   input  logic     reset,
   fetch_if.buffer  fq,
   issue_if.buffer  iq
);

   localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CW = $clog2(QUEUE_DEPTH + 1);

   T              mem [QUEUE_DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          flush;
   logic          do_push;
   logic          do_pop;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
      if (ptr == PW'(QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign flush   = fq.flush | iq.flush;
   assign do_push = fq.push_valid & ~flush;   // Wrong-path word dropped
   assign do_pop  = iq.pop & (count != '0) & ~flush;

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CW'(do_push) - CW'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= fq.push_pkt;
      end
   end

   assign iq.valid  = (count != '0);
   assign iq.pkt    = mem[rd_ptr];
   assign fq.credit = do_pop;   // Nothing returned for flushed entries

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [4:0]                 rs1_i,
   input  logic [4:0]                 rs2_i,
   input  logic [4:0]                 rd_i,
   input  logic                       we_i,
   input  logic [rv32_pkg::XLEN-1:0]  wdata_i,
   output logic [rv32_pkg::XLEN-1:0]  rdata1_o,
   output logic [rv32_pkg::XLEN-1:0]  rdata2_o
);

   logic [rv32_pkg::XLEN-1:0] regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (rd_i != 5'd0)) begin   // x0 stays zero
         regs[rd_i] <= wdata_i;
      end
   end

   assign rdata1_o = regs[rs1_i];
   assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       halt_i,
   issue_if.consumer                  iq,
   output logic [4:0]                 rs1_o,
   output logic [4:0]                 rs2_o,
   input  logic [rv32_pkg::XLEN-1:0]  rdata1_i,
   input  logic [rv32_pkg::XLEN-1:0]  rdata2_i,
   output logic [4:0]                 rd_o,
   output logic                       we_o,
   output logic [rv32_pkg::XLEN-1:0]  wdata_o,
   output logic                       redirect_o,
   output logic [rv32_pkg::XLEN-1:0]  target_o,
   output logic                       retire_valid_o,
   output logic [rv32_pkg::XLEN-1:0]  retire_pc_o,
   output logic [4:0]                 retire_rd_o,
   output logic                       retire_we_o,
   output logic [rv32_pkg::XLEN-1:0]  retire_data_o
);

   logic [rv32_pkg::XLEN-1:0] instr;
   logic [rv32_pkg::XLEN-1:0] pc;
   rv32_pkg::opcode_e         opcode;
   rv32_pkg::alu_op_e         op;
   logic [2:0]                funct3;
   logic [rv32_pkg::XLEN-1:0] operand_b;
   logic [rv32_pkg::XLEN-1:0] result;
   logic                      taken;
   logic                      writes;
   logic                      fire;

   // OP and OP_IMM share this mapping
   function automatic rv32_pkg::alu_op_e alu_from_f3(input logic [2:0] f3);
      case (f3)
         rv32_pkg::F3_ADD: return rv32_pkg::ALU_ADD;
         rv32_pkg::F3_SLT: return rv32_pkg::ALU_SLT;
         rv32_pkg::F3_XOR: return rv32_pkg::ALU_XOR;
         rv32_pkg::F3_OR:  return rv32_pkg::ALU_OR;
         rv32_pkg::F3_AND: return rv32_pkg::ALU_AND;
         default:          return rv32_pkg::ALU_ILLEGAL;
      endcase
   endfunction

   assign instr  = iq.pkt.instr;
   assign pc     = iq.pkt.pc;
   assign opcode = rv32_pkg::opcode_e'(instr[6:0]);
   assign funct3 = rv32_pkg::get_funct3(instr);
   assign fire   = iq.valid & ~halt_i;

   always_comb begin
      op = rv32_pkg::ALU_ILLEGAL;
      case (opcode)
         rv32_pkg::OPC_LUI:    op = rv32_pkg::ALU_PASS_B;
         rv32_pkg::OPC_JAL:    op = rv32_pkg::ALU_JAL;
         rv32_pkg::OPC_OP_IMM: op = alu_from_f3(funct3);
         rv32_pkg::OPC_BRANCH: begin
            if (funct3 == rv32_pkg::F3_BEQ) begin
               op = rv32_pkg::ALU_BEQ;
            end else if (funct3 == rv32_pkg::F3_BNE) begin
               op = rv32_pkg::ALU_BNE;
            end
         end
         rv32_pkg::OPC_OP: begin
            if (rv32_pkg::get_funct7(instr) == rv32_pkg::F7_BASE) begin
               op = alu_from_f3(funct3);
            end else if (rv32_pkg::get_funct7(instr) == rv32_pkg::F7_SUB &&
                         funct3 == rv32_pkg::F3_ADD) begin
               op = rv32_pkg::ALU_SUB;
            end
         end
         default: op = rv32_pkg::ALU_ILLEGAL;
      endcase
   end

   assign operand_b = (opcode == rv32_pkg::OPC_OP) ? rdata2_i : rv32_pkg::imm_i(instr);

   always_comb begin
      result   = '0;
      taken    = 1'b0;
      target_o = pc + rv32_pkg::imm_b(instr);
      case (op)
         rv32_pkg::ALU_ADD:    result = rdata1_i + operand_b;
         rv32_pkg::ALU_SUB:    result = rdata1_i - operand_b;
         rv32_pkg::ALU_AND:    result = rdata1_i & operand_b;
         rv32_pkg::ALU_OR:     result = rdata1_i | operand_b;
         rv32_pkg::ALU_XOR:    result = rdata1_i ^ operand_b;
         rv32_pkg::ALU_SLT:    result = {31'b0, $signed(rdata1_i) < $signed(operand_b)};
         rv32_pkg::ALU_PASS_B: result = rv32_pkg::imm_u(instr);
         rv32_pkg::ALU_BEQ:    taken = (rdata1_i == rdata2_i);
         rv32_pkg::ALU_BNE:    taken = (rdata1_i != rdata2_i);
         rv32_pkg::ALU_JAL: begin
            result   = pc + 32'd4;   // Link value
            taken    = 1'b1;
            target_o = pc + rv32_pkg::imm_j(instr);
         end
         default: result = '0;
      endcase
   end

   assign writes = (op != rv32_pkg::ALU_BEQ) && (op != rv32_pkg::ALU_BNE) &&
                   (op != rv32_pkg::ALU_ILLEGAL);

   assign rs1_o      = rv32_pkg::get_rs1(instr);
   assign rs2_o      = rv32_pkg::get_rs2(instr);
   assign rd_o       = rv32_pkg::get_rd(instr);
   assign we_o       = fire & writes;
   assign wdata_o    = result;
   assign redirect_o = fire & taken;
   assign iq.pop     = fire;
   assign iq.flush   = redirect_o;   // Younger entries are wrong path

   always_ff @(posedge clk) begin
      if (reset) begin
         retire_valid_o <= 1'b0;
      end else begin
         retire_valid_o <= fire;
      end
   end

   // Report lines for the instruction retired above
   always_ff @(posedge clk) begin
      if (fire) begin
         retire_pc_o   <= pc;
         retire_rd_o   <= rd_o;
         retire_we_o   <= writes;
         retire_data_o <= result;
      end
   end

endmodule

`default_nettype wire

/* src/rv32_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32_core #(
   parameter int QUEUE_DEPTH = pipe_pkg::DEF_QUEUE_DEPTH,
   parameter int IMEM_WORDS  = pipe_pkg::DEF_IMEM_WORDS
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            imem_we_i,
   input  logic [$clog2(IMEM_WORDS)-1:0]   imem_addr_i,
   input  logic [rv32_pkg::XLEN-1:0]       imem_data_i,
   input  logic                            run_i,
   input  logic                            halt_i,
   output logic                            retire_valid_o,
   output logic [rv32_pkg::XLEN-1:0]       retire_pc_o,
   output logic [4:0]                      retire_rd_o,
   output logic                            retire_we_o,
   output logic [rv32_pkg::XLEN-1:0]       retire_data_o
);

   logic                      redirect;
   logic [rv32_pkg::XLEN-1:0] target;
   logic [4:0]                rs1;
   logic [4:0]                rs2;
   logic [4:0]                rd;
   logic                      we;
   logic [rv32_pkg::XLEN-1:0] wdata;
   logic [rv32_pkg::XLEN-1:0] rdata1;
   logic [rv32_pkg::XLEN-1:0] rdata2;

   fetch_if fetch_bus ();
   issue_if issue_bus ();

   fetch_unit #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .IMEM_WORDS  (IMEM_WORDS)
   ) u_fetch (
      .clk         (clk),
      .reset       (reset),
      .run_i       (run_i),
      .imem_we_i   (imem_we_i),
      .imem_addr_i (imem_addr_i),
      .imem_data_i (imem_data_i),
      .redirect_i  (redirect),
      .target_i    (target),
      .fq          (fetch_bus)
   );

   fetch_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_queue (
      .clk   (clk),
      .reset (reset),
      .fq    (fetch_bus),
      .iq    (issue_bus)
   );

   exec_unit u_exec (
      .clk            (clk),
      .reset          (reset),
      .halt_i         (halt_i),
      .iq             (issue_bus),
      .rs1_o          (rs1),
      .rs2_o          (rs2),
      .rdata1_i       (rdata1),
      .rdata2_i       (rdata2),
      .rd_o           (rd),
      .we_o           (we),
      .wdata_o        (wdata),
      .redirect_o     (redirect),
      .target_o       (target),
      .retire_valid_o (retire_valid_o),
      .retire_pc_o    (retire_pc_o),
      .retire_rd_o    (retire_rd_o),
      .retire_we_o    (retire_we_o),
      .retire_data_o  (retire_data_o)
   );

   reg_file u_regs (
      .clk      (clk),
      .reset    (reset),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .rd_i     (rd),
      .we_i     (we),
      .wdata_i  (wdata),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2)
   );

endmodule

`default_nettype wire

/* dv/iss_model.svh */
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

logic [31:0] prog_words [IMEM_WORDS];
int          prog_len;
logic [31:0] model_regs [32];
logic [31:0] model_pc;

function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [4:0] rs1, input int imm);
   logic [31:0] v;
   v = imm;
   return {v[11:0], rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] upper);
   return {upper, rd, 7'b0110111};
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input int offset);
   logic [31:0] v;
   v = offset;
   return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input int offset);
   logic [31:0] v;
   v = offset;
   return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
endfunction

// Unused words hold addi x0 with the word address as immediate
task automatic clear_program();
   for (int i = 0; i < IMEM_WORDS; i++) begin
      prog_words[AW'(i)] = i_type(3'b000, 5'd0, 5'd0, i);
   end
   prog_len = 0;
endtask

task automatic add_word(input logic [31:0] w);
   prog_words[AW'(prog_len)] = w;
   prog_len++;
endtask

task automatic model_reset();
   model_pc = '0;
   for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
   end
endtask

// Executes the instruction at model_pc and reports what should retire
task automatic model_step(output logic [31:0] exp_pc, output logic [4:0] exp_rd,
                          output logic exp_we, output logic [31:0] exp_data,
                          output bit self_loop);
   logic [31:0]       w;
   logic [31:0]       a;
   logic [31:0]       b;
   logic [31:0]       next_pc;
   rv32_pkg::alu_op_e op;
   w = prog_words[model_pc[AW+1:2]];
   a = model_regs[w[19:15]];
   if (w[6:0] == rv32_pkg::OPC_OP || w[6:0] == rv32_pkg::OPC_BRANCH) begin
      b = model_regs[w[24:20]];
   end else begin
      b = {{20{w[31]}}, w[31:20]};
   end
   op = rv32_pkg::ALU_ILLEGAL;
   case (w[6:0])
      rv32_pkg::OPC_LUI: op = rv32_pkg::ALU_PASS_B;
      rv32_pkg::OPC_JAL: op = rv32_pkg::ALU_JAL;
      rv32_pkg::OPC_BRANCH: begin
         if (w[14:12] == 3'b000) op = rv32_pkg::ALU_BEQ;
         else if (w[14:12] == 3'b001) op = rv32_pkg::ALU_BNE;
      end
      rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM: begin
         if (w[6:0] == rv32_pkg::OPC_OP && w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
            op = rv32_pkg::ALU_SUB;
         end else if (w[6:0] == rv32_pkg::OPC_OP_IMM || w[31:25] == 7'b0000000) begin
            case (w[14:12])
               3'b000:  op = rv32_pkg::ALU_ADD;
               3'b010:  op = rv32_pkg::ALU_SLT;
               3'b100:  op = rv32_pkg::ALU_XOR;
               3'b110:  op = rv32_pkg::ALU_OR;
               3'b111:  op = rv32_pkg::ALU_AND;
               default: op = rv32_pkg::ALU_ILLEGAL;
            endcase
         end
      end
      default: op = rv32_pkg::ALU_ILLEGAL;
   endcase
   exp_pc   = model_pc;
   exp_rd   = w[11:7];
   exp_we   = 1'b1;
   exp_data = '0;
   next_pc  = model_pc + 32'd4;
   case (op)
      rv32_pkg::ALU_ADD:    exp_data = a + b;
      rv32_pkg::ALU_SUB:    exp_data = a - b;
      rv32_pkg::ALU_AND:    exp_data = a & b;
      rv32_pkg::ALU_OR:     exp_data = a | b;
      rv32_pkg::ALU_XOR:    exp_data = a ^ b;
      rv32_pkg::ALU_SLT:    exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv32_pkg::ALU_PASS_B: exp_data = {w[31:12], 12'h000};
      rv32_pkg::ALU_JAL: begin
         exp_data = model_pc + 32'd4;
         next_pc  = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      rv32_pkg::ALU_BEQ, rv32_pkg::ALU_BNE: begin
         exp_we = 1'b0;
         if ((a == b) == (op == rv32_pkg::ALU_BEQ)) begin
            next_pc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         end
      end
      default: exp_we = 1'b0;
   endcase
   if (exp_we && exp_rd != 5'd0) begin
      model_regs[exp_rd] = exp_data;
   end
   self_loop = (next_pc == model_pc);
   model_pc  = next_pc;
endtask

`endif

/* dv/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_tb;

   localparam int QUEUE_DEPTH  = 4;
   localparam int IMEM_WORDS   = 256;
   localparam int AW           = $clog2(IMEM_WORDS);
   localparam int LOOP_RETIRES = 3;                 // Self-loop retires that end a test
   localparam int SETUP_CYCLES = IMEM_WORDS + 16;   // Reset and program load
   localparam int NUM_TESTS    = 4;

   logic          clk = 1'b0;
   logic          reset;
   logic          imem_we_i;
   logic [AW-1:0] imem_addr_i;
   logic [31:0]   imem_data_i;
   logic          run_i;
   logic          halt_i;
   logic          retire_valid_o;
   logic [31:0]   retire_pc_o;
   logic [4:0]    retire_rd_o;
   logic          retire_we_o;
   logic [31:0]   retire_data_o;

   integer        seed;
   int            halt_left;
   int            watch_budget;
   bit            budget_ready = 1'b0;

   `include "iss_model.svh"

   rv32_core #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .IMEM_WORDS  (IMEM_WORDS)
   ) uut (
      .clk            (clk),
      .reset          (reset),
      .imem_we_i      (imem_we_i),
      .imem_addr_i    (imem_addr_i),
      .imem_data_i    (imem_data_i),
      .run_i          (run_i),
      .halt_i         (halt_i),
      .retire_valid_o (retire_valid_o),
      .retire_pc_o    (retire_pc_o),
      .retire_rd_o    (retire_rd_o),
      .retire_we_o    (retire_we_o),
      .retire_data_o  (retire_data_o)
   );

   always #10 clk = ~clk;

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
      $display("Mismatch in test %s: %s expected %h, actual %h", name, what, expected, actual);
      $display("Testbench failed");
      $fatal(1, "retire check failed");
   endtask

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      run_i = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic load_program();
      for (int i = 0; i < IMEM_WORDS; i++) begin
         @(negedge clk);
         imem_we_i   = 1'b1;
         imem_addr_i = AW'(i);
         imem_data_i = prog_words[AW'(i)];
      end
      @(negedge clk);
      imem_we_i = 1'b0;
   endtask

   // Random bursts up to 8 cycles, longer than the queue can absorb
   task automatic drive_halt(input bit with_halt);
      if (!with_halt) begin
         halt_i = 1'b0;
      end else if (halt_left > 0) begin
         halt_i = 1'b1;
         halt_left--;
      end else begin
         halt_i = 1'b0;
         if (($random(seed) & 3) == 0) halt_left = 1 + int'($random(seed) & 7);
      end
   endtask

   task automatic alu_program();
      clear_program();
      add_word(i_type(rv32_pkg::F3_ADD, 5'd1, 5'd0, 5));
      add_word(i_type(rv32_pkg::F3_ADD, 5'd2, 5'd0, -3));
      add_word(r_type(rv32_pkg::F3_ADD, rv32_pkg::F7_BASE, 5'd3, 5'd1, 5'd2));
      add_word(r_type(rv32_pkg::F3_ADD, rv32_pkg::F7_SUB, 5'd4, 5'd2, 5'd1));
      add_word(r_type(rv32_pkg::F3_AND, rv32_pkg::F7_BASE, 5'd5, 5'd1, 5'd2));
      add_word(r_type(rv32_pkg::F3_OR, rv32_pkg::F7_BASE, 5'd6, 5'd1, 5'd2));
      add_word(r_type(rv32_pkg::F3_XOR, rv32_pkg::F7_BASE, 5'd7, 5'd1, 5'd2));
      add_word(r_type(rv32_pkg::F3_SLT, rv32_pkg::F7_BASE, 5'd8, 5'd2, 5'd1));   // -3 < 5
      add_word(r_type(rv32_pkg::F3_SLT, rv32_pkg::F7_BASE, 5'd9, 5'd1, 5'd2));
      add_word(i_type(rv32_pkg::F3_SLT, 5'd10, 5'd2, -1));
      add_word(i_type(rv32_pkg::F3_AND, 5'd11, 5'd2, 'h0f0));
      add_word(i_type(rv32_pkg::F3_OR, 5'd12, 5'd1, -16));
      add_word(i_type(rv32_pkg::F3_XOR, 5'd13, 5'd2, -1));
      add_word(lui_word(5'd14, 20'habcde));
      add_word(i_type(rv32_pkg::F3_ADD, 5'd14, 5'd14, -1));   // Borrow into upper bits
      add_word(r_type(rv32_pkg::F3_ADD, rv32_pkg::F7_SUB, 5'd15, 5'd14, 5'd3));
      add_word(jal_word(5'd0, 0));
   endtask

   task automatic flow_program();
      clear_program();
      add_word(i_type(rv32_pkg::F3_ADD, 5'd1, 5'd0, 7));
      add_word(i_type(rv32_pkg::F3_ADD, 5'd2, 5'd0, 7));
      add_word(branch_word(rv32_pkg::F3_BEQ, 5'd1, 5'd2, 8));    // Taken
      add_word(i_type(rv32_pkg::F3_ADD, 5'd3, 5'd0, 99));
      add_word(branch_word(rv32_pkg::F3_BNE, 5'd1, 5'd2, 8));    // Falls through
      add_word(i_type(rv32_pkg::F3_ADD, 5'd4, 5'd0, 1));
      add_word(branch_word(rv32_pkg::F3_BNE, 5'd1, 5'd4, 12));
      add_word(i_type(rv32_pkg::F3_ADD, 5'd5, 5'd0, 55));
      add_word(i_type(rv32_pkg::F3_ADD, 5'd5, 5'd0, 66));
      add_word(jal_word(5'd6, 8));                                 // Link 40
      add_word(i_type(rv32_pkg::F3_ADD, 5'd7, 5'd0, 77));
      add_word(branch_word(rv32_pkg::F3_BEQ, 5'd1, 5'd0, 8));
      add_word(i_type(rv32_pkg::F3_ADD, 5'd0, 5'd0, 123));
      add_word(r_type(rv32_pkg::F3_ADD, rv32_pkg::F7_BASE, 5'd8, 5'd0, 5'd1));
      add_word(jal_word(5'd0, 0));
   endtask

   // Length of a test in retires, from a dry run of the model
   task automatic count_retires(output int n);
      logic [31:0] e_pc;
      logic [4:0]  e_rd;
      logic        e_we;
      logic [31:0] e_data;
      bit          self_loop;
      int          loops;
      model_reset();
      loops = 0;
      n = 0;
      while (loops < LOOP_RETIRES) begin
         model_step(e_pc, e_rd, e_we, e_data, self_loop);
         n++;
         if (self_loop) loops++;
      end
   endtask

   task automatic run_test(input string name, input bit with_halt);
      logic [31:0] e_pc;
      logic [4:0]  e_rd;
      logic        e_we;
      logic [31:0] e_data;
      bit          self_loop;
      int          loops;
      apply_reset();
      load_program();
      model_reset();
      loops     = 0;
      halt_left = 0;
      run_i     = 1'b1;
      while (loops < LOOP_RETIRES) begin
         @(negedge clk);
         if (retire_valid_o) begin
            model_step(e_pc, e_rd, e_we, e_data, self_loop);
            if (self_loop) loops++;
            assert (retire_pc_o === e_pc)
               else report_mismatch(name, "pc", e_pc, retire_pc_o);
            assert (retire_we_o === e_we)
               else report_mismatch(name, "write enable", {31'b0, e_we}, {31'b0, retire_we_o});
            if (e_we) begin
               assert (retire_rd_o === e_rd)
                  else report_mismatch(name, "rd", {27'b0, e_rd}, {27'b0, retire_rd_o});
               assert (retire_data_o === e_data)
                  else report_mismatch(name, "data", e_data, retire_data_o);
            end
         end
         drive_halt(with_halt);
      end
      run_i  = 1'b0;
      halt_i = 1'b0;
   endtask

   initial begin
      int n;
      int total;
      seed        = 32'h749a73fc;
      reset       = 1'b1;
      run_i       = 1'b0;
      halt_i      = 1'b0;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      halt_left   = 0;
      total       = 0;
      alu_program();
      count_retires(n);
      total += 2 * n;
      flow_program();
      count_retires(n);
      total += 2 * n;
      watch_budget = 20 * total + NUM_TESTS * SETUP_CYCLES;
      budget_ready = 1'b1;

      alu_program();
      run_test("alu", 1'b0);
      flow_program();
      run_test("control_flow", 1'b0);
      alu_program();
      run_test("alu_halt", 1'b1);
      flow_program();
      run_test("control_flow_halt", 1'b1);

      $display("Testbench passed");
      $finish;
   end

   // Halted cycles do not use up the budget
   initial begin
      wait (budget_ready);
      while (watch_budget > 0) begin
         @(posedge clk);
         if (!halt_i) watch_budget--;
      end
      $display("Retirement stalled, the watchdog expired before all tests finished");
      $display("Testbench failed");
      $fatal(1, "watchdog timeout");
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+dv
src/rv32_pkg.sv
src/pipe_pkg.sv
src/fetch_if.sv
src/issue_if.sv
src/fetch_unit.sv
src/fetch_queue.sv
src/reg_file.sv
src/exec_unit.sv
src/rv32_core.sv
dv/core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f vlog.f --top-module core_tb -o core_tb_sim

out=$(./obj_dir/core_tb_sim 2>&1) || true
printf '%s\n' "$out"

# Exit status follows the search for the pass line
printf '%s\n' "$out" | grep -q "^Testbench passed$"
